// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_cart_loader
FILELIST  := sources.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sources.f ====
verilog/loader_pkg.sv
verilog/cart_pkg.sv
verilog/load_control.sv
verilog/header_parser.sv
verilog/cheat_assembler.sv
verilog/ram_filler.sv
verilog/cart_loader_top.sv
tb/loader_checker.sv
tb/tb_cart_loader.sv

// ==== tb/loader_checker.sv ====
// Output checker for the cartridge loader: compares DUT ports with expected values
`timescale 1ns/1ps

module loader_checker
	import loader_pkg::*;
	import cart_pkg::*;
#(
	parameter int FILL_ADDR_BITS = 10
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  logic [7:0]                ioctl_index,
	input  logic                      ioctl_wr,
	input  ioctl_addr_t               ioctl_addr,
	input  fill_mode_t                wram_init,
	input  fill_mode_t                aram_init,
	input  rom_type_t                 rom_type,
	input  mask_t                     rom_mask,
	input  mask_t                     ram_mask,
	input  logic                      pal,
	input  logic [CODE_FIELD_W-1:0]   code_flags, code_addr, code_compare, code_replace,
	input  logic                      code_valid, code_reset, clearing, fill_we,
	input  logic [FILL_ADDR_BITS-1:0] fill_addr,
	input  logic [7:0]                wram_fill_data, aram_fill_data,
	input  logic                      cart_active, spc_mode, core_reset,
	// Expected values and their strobes
	input  logic                      chk_hdr, chk_code, chk_spc,
	input  logic [7:0]                exp_rom_type,
	input  mask_t                     exp_rom_mask, exp_ram_mask,
	input  logic                      exp_pal, exp_spc,
	input  logic [4*CODE_FIELD_W-1:0] exp_code,
	output int                        error_count,
	output int                        check_count
);

	int   errors = 0;
	int   checks = 0;
	int   code_pulses = 0;
	int   fill_pulses = 0;
	int   fill_cycles = 0;
	int   fill_next = 0;
	logic clearing_q = 1'b0;
	logic cart_dl;
	logic spc_dl;
	logic cheat_first;

	assign error_count = errors;
	assign check_count = checks;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	// Power-on byte for one mode at one address
	function automatic logic [7:0] pattern_for(input fill_mode_t mode, input int a);
		logic [7:0] value;
		case (mode)
			STRIPE_9966: value = (a[8] != a[2]) ? 8'h66 : 8'h99;
			STRIPE_00FF: value = (a[9] != a[0]) ? 8'hFF : 8'h00;
			FILL_55:     value = 8'h55;
			default:     value = 8'hFF;
		endcase
		return value;
	endfunction

	// Mid-cycle sampling, all levels are settled here
	always @(negedge clk_sys) begin
		cart_dl     = ioctl_download && (ioctl_index[5:0] == IDX_CART);
		spc_dl      = ioctl_download && (ioctl_index[5:0] == IDX_SPC);
		cheat_first = ioctl_download && (ioctl_index == IDX_CHEAT) && ioctl_wr
			&& (ioctl_addr == '0);
		compare("cart_active", 32'(cart_active), 32'(cart_dl));
		compare("core_reset", 32'(core_reset), 32'(reset || cart_dl || spc_dl || clearing));
		compare("code_reset", 32'(code_reset), 32'(cart_dl || cheat_first));

		// ==========================================================
		// Fill walk
		// ==========================================================
		if (clearing && !clearing_q) begin
			fill_next   = 0;
			fill_pulses = 0;
			fill_cycles = 0;
		end
		if (clearing)
			fill_cycles++;
		if (fill_we) begin
			compare("clearing", 32'(clearing), 32'd1);
			compare("fill_addr", 32'(fill_addr), 32'(fill_next));
			compare("wram_fill_data", 32'(wram_fill_data), 32'(pattern_for(wram_init, fill_next)));
			compare("aram_fill_data", 32'(aram_fill_data), 32'(pattern_for(aram_init, fill_next)));
			fill_next++;
			fill_pulses++;
		end
		if (!clearing && clearing_q) begin
			compare("fill_we pulses", 32'(fill_pulses), 32'(1 << FILL_ADDR_BITS));
			// Two clocks per address
			compare("clearing cycles", 32'(fill_cycles), 32'(2 << FILL_ADDR_BITS));
		end
		clearing_q = clearing;

		// Cheat fields at the strobe
		if (code_valid) begin
			code_pulses++;
			compare("code_flags", code_flags, exp_code[127:96]);
			compare("code_addr", code_addr, exp_code[95:64]);
			compare("code_compare", code_compare, exp_code[63:32]);
			compare("code_replace", code_replace, exp_code[31:0]);
		end
		if (chk_code) begin
			compare("code_valid pulses", 32'(code_pulses), 32'd1);
			code_pulses = 0;
		end

		if (chk_hdr) begin
			compare("rom_type", 32'(rom_type), 32'(exp_rom_type));
			compare("rom_mask", 32'(rom_mask), 32'(exp_rom_mask));
			compare("ram_mask", 32'(ram_mask), 32'(exp_ram_mask));
			compare("pal", 32'(pal), 32'(exp_pal));
		end
		if (chk_spc)
			compare("spc_mode", 32'(spc_mode), 32'(exp_spc));
	end

endmodule

// ==== tb/loader_input.txt ====
# Columns: command word, then hex values
# opt hdr_mode region wram aram | wr index addr data | chk rom_type rom_mask ram_mask pal
# end | fill | cheat | spc expected_spc_mode
# AUTO header, word 0 gives type and sizes
opt 0 0 0 1
wr 00 000000 0209
end
chk 02 07FFFF 000000 0
fill
# Forced HiROM layout
opt 3 0 2 3
wr 00 000000 0000
wr 00 0101D6 0A00
wr 00 0101D8 0000
end
chk 01 0FFFFF 000000 0
fill
# Header region bit, then forced NTSC
opt 0 0 1 0
wr 00 000000 0131
wr 00 000002 0100
end
chk 01 0007FF 001FFF 1
fill
opt 0 1 1 0
chk 01 0007FF 001FFF 0
# Cheat codes from random words
cheat
cheat
# Sound file, then a cartridge
wr 01 000000 1234
end
spc 1
wr 00 000000 0209
end
spc 0
fill

// ==== tb/tb_cart_loader.sv ====
// Cartridge loader testbench: clock, reset, watchdog and file-driven stimulus
`timescale 1ns/1ps

module tb_cart_loader
	import loader_pkg::*;
	import cart_pkg::*;
();

	localparam int FILL_BITS = 10;
	localparam int MAX_CMDS  = 64;

	logic                    clk_sys;
	logic                    reset;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic                    ioctl_wr;
	ioctl_addr_t             ioctl_addr;
	ioctl_data_t             ioctl_dout;
	header_mode_t            header_mode;
	region_mode_t            region_mode;
	fill_mode_t              wram_init;
	fill_mode_t              aram_init;
	rom_type_t               rom_type;
	mask_t                   rom_mask;
	mask_t                   ram_mask;
	logic                    pal;
	logic [CODE_FIELD_W-1:0] code_flags, code_addr, code_compare, code_replace;
	logic                    code_valid, code_reset, clearing, fill_we;
	logic [FILL_BITS-1:0]    fill_addr;
	logic [7:0]              wram_fill_data, aram_fill_data;
	logic                    cart_active, spc_mode, core_reset;

	// Expected values for the checker
	logic                      chk_hdr, chk_code, chk_spc;
	logic [7:0]                exp_rom_type;
	mask_t                     exp_rom_mask, exp_ram_mask;
	logic                      exp_pal, exp_spc;
	logic [4*CODE_FIELD_W-1:0] exp_code;
	int                        error_count, check_count;

	// Command table read from the stimulus file
	logic [63:0] cmd_name [MAX_CMDS];
	logic [31:0] cmd_arg [MAX_CMDS][4];
	int          n_cmds = 0;
	int          n_fills = 0;
	int          tb_errors = 0;
	int          watchdog_cycles = 0;

	cart_loader_top #(.FILL_ADDR_BITS(FILL_BITS)) dut_i (.*);

	loader_checker #(.FILL_ADDR_BITS(FILL_BITS)) checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Watchdog, armed once the command count is known
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

	// ==========================================================
	// Stimulus helpers
	// ==========================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Number of hex values after a command word, -1 if unknown
	function automatic int arg_count(input logic [63:0] word);
		case (word)
			64'("opt"), 64'("chk"):                return 4;
			64'("wr"):                             return 3;
			64'("spc"):                            return 1;
			64'("end"), 64'("fill"), 64'("cheat"): return 0;
			default:                               return -1;
		endcase
	endfunction

	task automatic load_commands();
		int             fd;
		int             rc;
		int             n_args;
		int             k;
		logic [63:0]    word;
		logic [31:0]    value;
		logic [8*160-1:0] rest;
		fd = $fopen("tb/loader_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/loader_input.txt");
			tb_errors++;
			return;
		end
		while ($fscanf(fd, "%s", word) == 1) begin
			n_args = arg_count(word);
			if (word == 64'("#")) begin
				rc = $fgets(rest, fd);
			end else if (n_args < 0 || n_cmds == MAX_CMDS) begin
				$display("Stimulus file holds an unknown command or too many commands");
				tb_errors++;
			end else begin
				cmd_name[n_cmds] = word;
				for (k = 0; k < n_args; k++) begin
					rc = $fscanf(fd, "%h", value);
					cmd_arg[n_cmds][k] = value;
				end
				if (word == 64'("fill"))
					n_fills++;
				n_cmds++;
			end
		end
		$fclose(fd);
	endtask

	task automatic write_word(input logic [7:0] index, input ioctl_addr_t addr,
		input ioctl_data_t data);
		ioctl_download = 1'b1;
		ioctl_index    = index;
		ioctl_addr     = addr;
		ioctl_dout     = data;
		ioctl_wr       = 1'b1;
		next_cycle();
		ioctl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		next_cycle();
	endtask

	// Masks settle two edges after the last write, pal one edge after the end
	task automatic check_header(input logic [7:0] rtype, input mask_t rmask,
		input mask_t wmask, input logic region);
		repeat (3) next_cycle();
		exp_rom_type = rtype;
		exp_rom_mask = rmask;
		exp_ram_mask = wmask;
		exp_pal      = region;
		chk_hdr      = 1'b1;
		next_cycle();
		chk_hdr = 1'b0;
	endtask

	task automatic check_spc(input logic mode);
		repeat (2) next_cycle();
		exp_spc = mode;
		chk_spc = 1'b1;
		next_cycle();
		chk_spc = 1'b0;
	endtask

	task automatic wait_fill();
		while (!clearing)
			next_cycle();
		while (clearing)
			next_cycle();
		next_cycle();
	endtask

	// One cheat code from eight random words
	task automatic send_cheat();
		logic [15:0] w [8];
		int          k;
		for (k = 0; k < 8; k++)
			w[k] = 16'($urandom);
		exp_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		for (k = 0; k < 8; k++)
			write_word(8'hFF, ioctl_addr_t'(2 * k), w[k]);
		end_download();
		repeat (2) next_cycle();
		chk_code = 1'b1;
		next_cycle();
		chk_code = 1'b0;
	endtask

	task automatic run_command(input int i);
		logic [31:0] a [4];
		a = cmd_arg[i];
		case (cmd_name[i])
			64'("opt"): begin
				header_mode = header_mode_t'(a[0][2:0]);
				region_mode = region_mode_t'(a[1][1:0]);
				wram_init   = fill_mode_t'(a[2][1:0]);
				aram_init   = fill_mode_t'(a[3][1:0]);
				next_cycle();
			end
			64'("wr"):    write_word(a[0][7:0], a[1][24:0], a[2][15:0]);
			64'("end"):   end_download();
			64'("chk"):   check_header(a[0][7:0], a[1][23:0], a[2][23:0], a[3][0]);
			64'("fill"):  wait_fill();
			64'("cheat"): send_cheat();
			64'("spc"):   check_spc(a[0][0]);
			default: ;
		endcase
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin
		void'($urandom(26));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_mode    = HDR_AUTO;
		region_mode    = REGION_AUTO;
		wram_init      = STRIPE_9966;
		aram_init      = STRIPE_9966;
		chk_hdr        = 1'b0;
		chk_code       = 1'b0;
		chk_spc        = 1'b0;
		exp_rom_type   = '0;
		exp_rom_mask   = '0;
		exp_ram_mask   = '0;
		exp_pal        = 1'b0;
		exp_spc        = 1'b0;
		exp_code       = '0;

		load_commands();
		watchdog_cycles = 10 + n_cmds * 64 + n_fills * 4 * (1 << FILL_BITS);

		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_cycle();

		for (int i = 0; i < n_cmds; i++)
			run_command(i);
		repeat (4) next_cycle();

		$display("Summary: %0d checks, %0d errors", check_count, error_count + tb_errors);
		if (error_count + tb_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== verilog/cart_loader_top.sv ====
// Cartridge loading front end: download control, header parsing, cheats and memory fill
`timescale 1ns/1ps

module cart_loader_top
	import loader_pkg::*;
	import cart_pkg::*;
#(
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host download stream
	input  logic                      ioctl_download,
	input  logic [7:0]                ioctl_index,
	input  logic                      ioctl_wr,
	input  ioctl_addr_t               ioctl_addr,
	input  ioctl_data_t               ioctl_dout,
	// Menu options
	input  header_mode_t              header_mode,
	input  region_mode_t              region_mode,
	input  fill_mode_t                wram_init,
	input  fill_mode_t                aram_init,
	// Cartridge description
	output rom_type_t                 rom_type,
	output mask_t                     rom_mask,
	output mask_t                     ram_mask,
	output logic                      pal,
	// Cheats
	output logic [CODE_FIELD_W-1:0]   code_flags,
	output logic [CODE_FIELD_W-1:0]   code_addr,
	output logic [CODE_FIELD_W-1:0]   code_compare,
	output logic [CODE_FIELD_W-1:0]   code_replace,
	output logic                      code_valid,
	output logic                      code_reset,
	// Memory fill
	output logic                      clearing,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic                      fill_we,
	output logic [7:0]                wram_fill_data,
	output logic [7:0]                aram_fill_data,
	// Core control
	output logic                      cart_active,
	output logic                      spc_mode,
	output logic                      core_reset
);

	logic hdr_wr;
	logic code_wr;
	logic fill_start;

	// ==========================================================
	// Control
	// ==========================================================
	load_control load_control_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.clearing       (clearing),
		.cart_active    (cart_active),
		.hdr_wr         (hdr_wr),
		.code_wr        (code_wr),
		.code_reset     (code_reset),
		.fill_start     (fill_start),
		.spc_mode       (spc_mode),
		.core_reset     (core_reset)
	);

	// ==========================================================
	// Datapath
	// ==========================================================
	header_parser header_parser_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hdr_wr      (hdr_wr),
		.cart_active (cart_active),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.header_mode (header_mode),
		.region_mode (region_mode),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_assembler cheat_assembler_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.code_wr      (code_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.code_valid   (code_valid)
	);

	ram_filler #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) ram_filler_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.fill_start     (fill_start),
		.wram_init      (wram_init),
		.aram_init      (aram_init),
		.clearing       (clearing),
		.fill_addr      (fill_addr),
		.fill_we        (fill_we),
		.wram_fill_data (wram_fill_data),
		.aram_fill_data (aram_fill_data)
	);

endmodule

// ==== verilog/cart_pkg.sv ====
// Cartridge and memory definitions: masks, header and region modes, fill patterns, cheat fields
package cart_pkg;

	// ==========================================================
	// Cartridge description
	// ==========================================================
	typedef logic [23:0] mask_t;
	typedef logic [7:0]  rom_type_t;

	// Forced header layout, AUTO trusts the header itself
	typedef enum logic [2:0] {
		HDR_AUTO      = 3'd0,
		HDR_NO_HEADER = 3'd1,
		HDR_LOROM     = 3'd2,
		HDR_HIROM     = 3'd3,
		HDR_EXHIROM   = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_mode_t;

	// Power-on memory content
	typedef enum logic [1:0] {
		STRIPE_9966 = 2'd0,
		STRIPE_00FF = 2'd1,
		FILL_55     = 2'd2,
		FILL_FF     = 2'd3
	} fill_mode_t;

	localparam int CODE_FIELD_W = 32;

	// Size code 4'hC means 4 MB of ROM
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;
	localparam mask_t      MASK_UNIT        = 24'd1024;

endpackage

// ==== verilog/cheat_assembler.sv ====
// Cheat code assembler: eight download words form one code, then a strobe
`timescale 1ns/1ps

module cheat_assembler
	import loader_pkg::*;
	import cart_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    code_wr,
	input  ioctl_addr_t             ioctl_addr,
	input  ioctl_data_t             ioctl_dout,
	output logic [CODE_FIELD_W-1:0] code_flags,
	output logic [CODE_FIELD_W-1:0] code_addr,
	output logic [CODE_FIELD_W-1:0] code_compare,
	output logic [CODE_FIELD_W-1:0] code_replace,
	output logic                    code_valid
);

	localparam int HALF = CODE_FIELD_W / 2;

	// Field words, low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code_flags[HALF-1:0]              <= ioctl_dout;
				4'd2:  code_flags[CODE_FIELD_W-1:HALF]   <= ioctl_dout;
				4'd4:  code_addr[HALF-1:0]               <= ioctl_dout;
				4'd6:  code_addr[CODE_FIELD_W-1:HALF]    <= ioctl_dout;
				4'd8:  code_compare[HALF-1:0]            <= ioctl_dout;
				4'd10: code_compare[CODE_FIELD_W-1:HALF] <= ioctl_dout;
				4'd12: code_replace[HALF-1:0]            <= ioctl_dout;
				4'd14: code_replace[CODE_FIELD_W-1:HALF] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of a code clocks it into the core
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

// ==== verilog/header_parser.sv ====
// Cartridge header parser: ROM type, ROM and RAM masks, video region
`timescale 1ns/1ps

module header_parser
	import loader_pkg::*;
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         hdr_wr,
	input  logic         cart_active,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_data_t  ioctl_dout,
	input  header_mode_t header_mode,
	input  region_mode_t region_mode,
	output rom_type_t    rom_type,
	output mask_t        rom_mask,
	output mask_t        ram_mask,
	output logic         pal
);

	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic       hdr_region;

	// ==========================================================
	// Header capture
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_type   <= '0;
			hdr_region <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'h0;
				if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00)
					{ram_size, rom_size} <= ioctl_dout[7:0];

				case (header_mode)
					HDR_NO_HEADER, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:                rom_type <= 8'd1;
					HDR_EXHIROM:              rom_type <= 8'd2;
					default:                  rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == ioctl_addr_t'(2))
				hdr_region <= ioctl_dout[8];

			// Forced layouts read the sizes from the internal header
			case (header_mode)
				HDR_LOROM: begin
					if (ioctl_addr == HDR_LO_SIZE) rom_size <= ioctl_dout[11:8];
					if (ioctl_addr == HDR_LO_RAM)  ram_size <= ioctl_dout[3:0];
				end
				HDR_HIROM: begin
					if (ioctl_addr == HDR_HI_SIZE) rom_size <= ioctl_dout[11:8];
					if (ioctl_addr == HDR_HI_RAM)  ram_size <= ioctl_dout[3:0];
				end
				HDR_EXHIROM: begin
					if (ioctl_addr == HDR_EX_SIZE) rom_size <= ioctl_dout[11:8];
					if (ioctl_addr == HDR_EX_RAM)  ram_size <= ioctl_dout[3:0];
				end
				default: ;
			endcase
		end
	end

	// Masks trail the size codes by one clock
	always_ff @(posedge clk_sys) begin
		rom_mask <= (MASK_UNIT << rom_size) - mask_t'(1);
		ram_mask <= (ram_size != 4'h0) ? (MASK_UNIT << ram_size) - mask_t'(1) : '0;
	end

	// ==========================================================
	// Region, frozen while a cartridge loads
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal <= 1'b0;
		end else if (!cart_active) begin
			case (region_mode)
				REGION_AUTO: pal <= hdr_region;
				REGION_NTSC: pal <= 1'b0;
				default:     pal <= 1'b1;
			endcase
		end
	end

endmodule

// ==== verilog/load_control.sv ====
// Download decoder: file type detection, strobe gating, fill start and core reset
`timescale 1ns/1ps

module load_control
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  logic        clearing,
	output logic        cart_active,
	output logic        hdr_wr,
	output logic        code_wr,
	output logic        code_reset,
	output logic        fill_start,
	output logic        spc_mode,
	output logic        core_reset
);

	logic spc_active;
	logic code_active;
	logic cart_active_q;

	// File type decode
	assign cart_active = ioctl_download && (ioctl_index[5:0] == IDX_CART);
	assign spc_active  = ioctl_download && (ioctl_index[5:0] == IDX_SPC);
	assign code_active = ioctl_download && (ioctl_index == IDX_CHEAT);

	assign hdr_wr  = cart_active && ioctl_wr;
	assign code_wr = code_active && ioctl_wr;

	// Cheat list restarts with its first word or a new cartridge
	assign code_reset = (code_wr && (ioctl_addr == '0)) || cart_active;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_active_q <= 1'b0;
			spc_mode      <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			// Last write decides the mode
			if (ioctl_wr)
				spc_mode <= spc_active;
		end
	end

	// First cycle of a cartridge download
	assign fill_start = cart_active && !cart_active_q;

	assign core_reset = reset || cart_active || spc_active || clearing;

endmodule

// ==== verilog/loader_pkg.sv ====
// Host download stream definitions: bus widths, file index codes and header offsets
package loader_pkg;

	// ==========================================================
	// Download bus
	// ==========================================================
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;

	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [IOCTL_DATA_W-1:0] ioctl_data_t;

	// File index codes, cart and sound file decode on the low six bits
	localparam logic [5:0] IDX_CART  = 6'h00;
	localparam logic [5:0] IDX_SPC   = 6'h01;
	localparam logic [7:0] IDX_CHEAT = 8'hFF;

	// ==========================================================
	// Cartridge header locations
	// ==========================================================
	localparam ioctl_addr_t HDR_COPIER = 25'd512;

	// Size and RAM words, copier header included
	localparam ioctl_addr_t HDR_LO_SIZE = 25'h007FD6 + HDR_COPIER;
	localparam ioctl_addr_t HDR_HI_SIZE = 25'h00FFD6 + HDR_COPIER;
	localparam ioctl_addr_t HDR_EX_SIZE = 25'h40FFD6 + HDR_COPIER;
	localparam ioctl_addr_t HDR_LO_RAM  = 25'h007FD8 + HDR_COPIER;
	localparam ioctl_addr_t HDR_HI_RAM  = 25'h00FFD8 + HDR_COPIER;
	localparam ioctl_addr_t HDR_EX_RAM  = 25'h40FFD8 + HDR_COPIER;

endpackage

// ==== verilog/ram_filler.sv ====
// Power-on memory fill: two-cycle address walk and selectable fill patterns
`timescale 1ns/1ps

module ram_filler
	import cart_pkg::*;
#(
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      fill_start,
	input  fill_mode_t                wram_init,
	input  fill_mode_t                aram_init,
	output logic                      clearing,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic                      fill_we,
	output logic [7:0]                wram_fill_data,
	output logic [7:0]                aram_fill_data
);

	logic fill_wait;

	// Pattern rules of the different console revisions
	function automatic logic [7:0] fill_pattern(input fill_mode_t mode,
		input logic [FILL_ADDR_BITS-1:0] addr);
		case (mode)
			STRIPE_9966: fill_pattern = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			STRIPE_00FF: fill_pattern = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			FILL_55:     fill_pattern = 8'h55;
			default:     fill_pattern = 8'hFF;
		endcase
	endfunction

	// Write cycle, then wait cycle, then next address
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
			fill_wait <= 1'b0;
		end else if (fill_start) begin
			clearing  <= 1'b1;
			fill_addr <= '0;
			fill_wait <= 1'b0;
		end else if (clearing) begin
			fill_wait <= !fill_wait;
			if (fill_wait) begin
				fill_addr <= fill_addr + 1'b1;
				// Done after the wait cycle of the top address
				if (&fill_addr)
					clearing <= 1'b0;
			end
		end
	end

	assign fill_we = clearing && !fill_wait;

	assign wram_fill_data = fill_pattern(wram_init, fill_addr);
	assign aram_fill_data = fill_pattern(aram_init, fill_addr);

endmodule
